//--- priv_pkg.sv
`default_nettype none

package priv_pkg;

    typedef logic [31:0] xlen_t;

    // bits 9:8 lowest privilege, bits 11:10 == 3 read-only
    typedef logic [11:0] csr_idx_t;

    typedef enum logic [1:0] {
        MODE_U = 2'b00,
        MODE_M = 2'b11
    } priv_mode_t;

    // machine csr addresses
    localparam csr_idx_t CSR_MSTATUS = 12'h300;
    localparam csr_idx_t CSR_MIE     = 12'h304;
    localparam csr_idx_t CSR_MTVEC   = 12'h305;
    localparam csr_idx_t CSR_MEPC    = 12'h341;
    localparam csr_idx_t CSR_MCAUSE  = 12'h342;
    localparam csr_idx_t CSR_MTVAL   = 12'h343;
    localparam csr_idx_t CSR_MIP     = 12'h344;
    localparam csr_idx_t CSR_MHARTID = 12'hF14;

    // mstatus fields
    localparam int unsigned MSTATUS_MIE_BIT  = 3;
    localparam int unsigned MSTATUS_MPIE_BIT = 7;
    localparam int unsigned MSTATUS_MPP_LSB  = 11;

    // external interrupt position shared by mie and mip
    localparam int unsigned MIE_MEIE_BIT = 11;

    // cause codes
    localparam xlen_t CAUSE_ILLEGAL   = 32'd2;
    localparam xlen_t CAUSE_ECALL_U   = 32'd8;
    localparam xlen_t CAUSE_ECALL_M   = 32'd11;
    localparam xlen_t CAUSE_M_EXT_IRQ = 32'h8000_000B;

endpackage

`default_nettype wire

//--- csr_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface csr_port_if import priv_pkg::*; ();

    logic     access;
    csr_idx_t read_idx;
    xlen_t    read_val;
    logic     illegal;
    logic     write;
    csr_idx_t write_idx;
    xlen_t    write_val;

    modport requester (
        output access, read_idx, write, write_idx, write_val,
        input  read_val, illegal
    );

    modport csr (
        input  access, read_idx, write, write_idx, write_val,
        output read_val, illegal
    );

endinterface

`default_nettype wire

//--- trap_if.sv
`timescale 1ns/1ps
`default_nettype none

interface trap_if import priv_pkg::*; ();

    logic  take_trap;
    xlen_t cause;
    xlen_t epc;
    xlen_t tval;
    // return from trap when no trap is taken
    logic  do_mret;

    modport source (
        output take_trap, cause, epc, tval, do_mret
    );

    modport sink (
        input take_trap, cause, epc, tval, do_mret
    );

endinterface

`default_nettype wire

//--- priv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module priv_ctrl import priv_pkg::*; #(
    parameter int unsigned HART_ID = 0
) (
    input wire clk,
    input wire rst,
    input wire i_irq,

    trap_if.sink    if_trap,
    csr_port_if.csr if_csr,

    output priv_mode_t o_mode,
    output logic       o_mstatus_mie,
    output logic       o_meie,
    output xlen_t      o_mtvec,
    output xlen_t      o_mepc
);
    priv_mode_t cur_mode;

    // only the legal fields are stored
    logic       mstatus_mie;
    logic       mstatus_mpie;
    priv_mode_t mstatus_mpp;
    logic [29:0] mtvec_base;
    logic       mtvec_mode;
    logic       mie_meie;
    xlen_t      mepc;
    xlen_t      mcause;
    xlen_t      mtval;

    xlen_t mstatus_val;
    xlen_t mtvec_val;
    xlen_t mie_val;
    xlen_t mip_val;
    xlen_t csr_rdata;
    logic  rd_illegal;
    logic  wr_illegal;
    logic  csr_we;

    always_comb begin
        mstatus_val = '0;
        mstatus_val[MSTATUS_MIE_BIT] = mstatus_mie;
        mstatus_val[MSTATUS_MPIE_BIT] = mstatus_mpie;
        mstatus_val[MSTATUS_MPP_LSB +: 2] = mstatus_mpp;
        mie_val = '0;
        mie_val[MIE_MEIE_BIT] = mie_meie;
        mip_val = '0;
        mip_val[MIE_MEIE_BIT] = i_irq;
    end

    assign mtvec_val = {mtvec_base, 1'b0, mtvec_mode};

    // privilege field of the address against current mode
    assign rd_illegal = if_csr.access && (if_csr.read_idx[9:8] > 2'(cur_mode));

    // mip mirrors the irq line, so it is treated as read-only too
    assign wr_illegal = if_csr.write &&
        ((if_csr.write_idx[9:8] > 2'(cur_mode)) ||
         (if_csr.write_idx[11:10] == 2'b11) ||
         (if_csr.write_idx == CSR_MIP));

    assign csr_we = if_csr.write && !wr_illegal;

    always_comb begin
        case (if_csr.read_idx)
            CSR_MSTATUS: csr_rdata = mstatus_val;
            CSR_MIE:     csr_rdata = mie_val;
            CSR_MTVEC:   csr_rdata = mtvec_val;
            CSR_MEPC:    csr_rdata = mepc;
            CSR_MCAUSE:  csr_rdata = mcause;
            CSR_MTVAL:   csr_rdata = mtval;
            CSR_MIP:     csr_rdata = mip_val;
            CSR_MHARTID: csr_rdata = xlen_t'(HART_ID);
            default:     csr_rdata = '0;
        endcase
    end

    assign if_csr.illegal = rd_illegal || wr_illegal;
    assign if_csr.read_val = (if_csr.access && !if_csr.illegal) ? csr_rdata : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_mode <= MODE_M;
            mstatus_mie <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp <= MODE_M;
            mtvec_base <= '0;
            mtvec_mode <= 1'b0;
            mie_meie <= 1'b0;
            mepc <= '0;
            mcause <= '0;
            mtval <= '0;
        end else if (csr_we) begin
            case (if_csr.write_idx)
                CSR_MSTATUS: begin
                    mstatus_mie <= if_csr.write_val[MSTATUS_MIE_BIT];
                    mstatus_mpie <= if_csr.write_val[MSTATUS_MPIE_BIT];
                    // no S mode, so anything but M maps to U
                    mstatus_mpp <= (if_csr.write_val[MSTATUS_MPP_LSB +: 2] == 2'b11) ?
                        MODE_M : MODE_U;
                end
                CSR_MTVEC: begin
                    mtvec_base <= if_csr.write_val[31:2];
                    mtvec_mode <= if_csr.write_val[0];
                end
                CSR_MIE:    mie_meie <= if_csr.write_val[MIE_MEIE_BIT];
                CSR_MEPC:   mepc <= if_csr.write_val;
                CSR_MCAUSE: mcause <= if_csr.write_val;
                CSR_MTVAL:  mtval <= if_csr.write_val;
                default: begin
                end
            endcase
        end else if (if_trap.take_trap) begin
            mepc <= if_trap.epc;
            mcause <= if_trap.cause;
            mtval <= if_trap.tval;
            mstatus_mpie <= mstatus_mie;
            mstatus_mie <= 1'b0;
            mstatus_mpp <= cur_mode;
            cur_mode <= MODE_M;
        end else if (if_trap.do_mret) begin
            cur_mode <= mstatus_mpp;
            mstatus_mie <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
            mstatus_mpp <= MODE_U;
        end
    end

    assign o_mode = cur_mode;
    assign o_mstatus_mie = mstatus_mie;
    assign o_meie = mie_meie;
    assign o_mtvec = mtvec_val;
    assign o_mepc = mepc;

endmodule

`default_nettype wire

//--- trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl import priv_pkg::*; (
    input wire             i_ecall,
    input wire             i_illegal,
    input wire             i_mret,
    input wire             i_irq,
    input wire xlen_t      i_pc,
    input wire xlen_t      i_tval,
    input wire priv_mode_t i_mode,
    input wire             i_mstatus_mie,
    input wire             i_meie,
    input wire xlen_t      i_mtvec,
    input wire xlen_t      i_mepc,

    trap_if.source if_trap,

    output logic  o_redirect,
    output xlen_t o_redirect_pc
);
    logic  irq_taken;
    logic  mret_in_u;
    logic  take_trap;
    logic  do_mret;
    xlen_t cause;
    xlen_t tval;
    xlen_t tvec_base;

    assign irq_taken = i_irq && i_mstatus_mie && i_meie;
    // mret is privileged so from U it is an illegal instruction
    assign mret_in_u = i_mret && (i_mode == MODE_U);
    assign tvec_base = {i_mtvec[31:2], 2'b00};

    // irq first, then illegal, ecall and mret
    always_comb begin
        take_trap = 1'b1;
        do_mret = 1'b0;
        cause = '0;
        tval = '0;
        if (irq_taken) begin
            cause = CAUSE_M_EXT_IRQ;
        end else if (i_illegal || mret_in_u) begin
            cause = CAUSE_ILLEGAL;
            tval = i_illegal ? i_tval : '0;
        end else if (i_ecall) begin
            cause = (i_mode == MODE_M) ? CAUSE_ECALL_M : CAUSE_ECALL_U;
        end else begin
            take_trap = 1'b0;
            do_mret = i_mret;
        end
    end

    always_comb begin
        if (take_trap) begin
            // vectored only applies to interrupts
            if (i_mtvec[0] && cause[31]) begin
                o_redirect_pc = tvec_base + {cause[29:0], 2'b00};
            end else begin
                o_redirect_pc = tvec_base;
            end
        end else if (do_mret) begin
            o_redirect_pc = i_mepc;
        end else begin
            o_redirect_pc = '0;
        end
    end

    assign o_redirect = take_trap || do_mret;

    assign if_trap.take_trap = take_trap;
    assign if_trap.do_mret = do_mret;
    assign if_trap.cause = cause;
    assign if_trap.epc = i_pc;
    assign if_trap.tval = tval;

endmodule

`default_nettype wire

//--- machine_priv_unit.sv
`timescale 1ns/1ps
`default_nettype none

module machine_priv_unit import priv_pkg::*; #(
    parameter int unsigned HART_ID = 0
) (
    input wire           clk,
    input wire           rst,

    input wire           i_csr_access,
    input wire csr_idx_t i_csr_read_idx,
    input wire           i_csr_write,
    input wire csr_idx_t i_csr_write_idx,
    input wire xlen_t    i_csr_write_val,

    input wire           i_ecall,
    input wire           i_illegal,
    input wire           i_mret,
    input wire           i_irq,
    input wire xlen_t    i_pc,
    input wire xlen_t    i_tval,

    output xlen_t        o_csr_read_val,
    output logic         o_csr_illegal,
    output priv_mode_t   o_mode,
    output logic         o_redirect,
    output xlen_t        o_redirect_pc
);
    logic  mstatus_mie;
    logic  meie;
    xlen_t mtvec;
    xlen_t mepc;

    csr_port_if csr_port ();
    trap_if     trap_port ();

    assign csr_port.access = i_csr_access;
    assign csr_port.read_idx = i_csr_read_idx;
    assign csr_port.write = i_csr_write;
    assign csr_port.write_idx = i_csr_write_idx;
    assign csr_port.write_val = i_csr_write_val;
    assign o_csr_read_val = csr_port.read_val;
    assign o_csr_illegal = csr_port.illegal;

    priv_ctrl #(
        .HART_ID (HART_ID)
    ) priv_ctrl_inst (
        .clk           (clk),
        .rst           (rst),
        .i_irq         (i_irq),
        .if_trap       (trap_port.sink),
        .if_csr        (csr_port.csr),
        .o_mode        (o_mode),
        .o_mstatus_mie (mstatus_mie),
        .o_meie        (meie),
        .o_mtvec       (mtvec),
        .o_mepc        (mepc)
    );

    trap_ctrl trap_ctrl_inst (
        .i_ecall       (i_ecall),
        .i_illegal     (i_illegal),
        .i_mret        (i_mret),
        .i_irq         (i_irq),
        .i_pc          (i_pc),
        .i_tval        (i_tval),
        .i_mode        (o_mode),
        .i_mstatus_mie (mstatus_mie),
        .i_meie        (meie),
        .i_mtvec       (mtvec),
        .i_mepc        (mepc),
        .if_trap       (trap_port.source),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

endmodule

`default_nettype wire

//--- machine_priv_unit_sva.sv
`timescale 1ns/1ps
`default_nettype none

module machine_priv_unit_sva import priv_pkg::*; (
    input wire             clk,
    input wire             rst,
    input wire             i_ecall,
    input wire             i_illegal,
    input wire             i_mret,
    input wire             i_irq,
    input wire             i_csr_access,
    input wire             i_csr_illegal,
    input wire xlen_t      i_csr_read_val,
    input wire             i_redirect,
    input wire             i_take_trap,
    input wire priv_mode_t i_mode
);

    int unsigned fail_count = 0;

    redirect_needs_event: assert property (
        @(posedge clk) disable iff (rst)
        i_redirect |-> (i_ecall || i_illegal || i_mret || i_irq)
    ) else begin
        fail_count++;
        $error("redirect raised with no event input");
    end

    illegal_reads_zero: assert property (
        @(posedge clk) disable iff (rst)
        (i_csr_access && i_csr_illegal) |-> (i_csr_read_val == '0)
    ) else begin
        fail_count++;
        $error("illegal csr access returned a nonzero value");
    end

    // trap state lands one edge later
    trap_enters_m: assert property (
        @(posedge clk) disable iff (rst)
        i_take_trap |=> (i_mode == MODE_M)
    ) else begin
        fail_count++;
        $error("mode is not M in the cycle after a trap");
    end

endmodule

bind machine_priv_unit machine_priv_unit_sva machine_priv_unit_sva_inst (
    .clk            (clk),
    .rst            (rst),
    .i_ecall        (i_ecall),
    .i_illegal      (i_illegal),
    .i_mret         (i_mret),
    .i_irq          (i_irq),
    .i_csr_access   (i_csr_access),
    .i_csr_illegal  (o_csr_illegal),
    .i_csr_read_val (o_csr_read_val),
    .i_redirect     (o_redirect),
    .i_take_trap    (trap_port.take_trap),
    .i_mode         (o_mode)
);

`default_nettype wire

//--- tb_machine_priv_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_machine_priv_unit import priv_pkg::*; ();

    localparam int unsigned HART_ID = 5;
    // reset plus the scripted stimulus below takes about 73 cycles
    localparam int SCRIPT_CYCLES = 75;
    localparam int CYCLE_LIMIT = 2 * SCRIPT_CYCLES;

    typedef struct packed {
        logic     access;
        csr_idx_t ridx;
        logic     write;
        csr_idx_t widx;
        xlen_t    wval;
        logic     ecall;
        logic     illegal;
        logic     mret;
        logic     irq;
        xlen_t    pc;
        xlen_t    tval;
    } stim_t;

    // architectural state with csr words already legalized
    typedef struct packed {
        priv_mode_t mode;
        xlen_t      mstatus;
        xlen_t      mtvec;
        xlen_t      mie;
        xlen_t      mepc;
        xlen_t      mcause;
        xlen_t      mtval;
    } model_t;

    logic       clk;
    logic       rst;
    stim_t      stim;
    logic       irq_level;
    xlen_t      lfsr_state;
    int         errors;
    int         checks;
    int         cycles;
    int         sva_fails;

    xlen_t      csr_read_val;
    logic       csr_illegal;
    priv_mode_t mode;
    logic       redirect;
    xlen_t      redirect_pc;

    model_t     model;
    model_t     model_next;
    logic       exp_ill;
    logic       exp_redir;
    xlen_t      exp_rval;
    xlen_t      exp_pc;

    machine_priv_unit #(
        .HART_ID (HART_ID)
    ) machine_priv_unit_inst (
        .clk             (clk),
        .rst             (rst),
        .i_csr_access    (stim.access),
        .i_csr_read_idx  (stim.ridx),
        .i_csr_write     (stim.write),
        .i_csr_write_idx (stim.widx),
        .i_csr_write_val (stim.wval),
        .i_ecall         (stim.ecall),
        .i_illegal       (stim.illegal),
        .i_mret          (stim.mret),
        .i_irq           (stim.irq),
        .i_pc            (stim.pc),
        .i_tval          (stim.tval),
        .o_csr_read_val  (csr_read_val),
        .o_csr_illegal   (csr_illegal),
        .o_mode          (mode),
        .o_redirect      (redirect),
        .o_redirect_pc   (redirect_pc)
    );

    always #10 clk = ~clk;

    // galois lfsr stepped once per bit
    function automatic xlen_t rand_bits(input int unsigned nbits);
        xlen_t value;
        logic  out_bit;
        value = '0;
        for (int unsigned i = 0; i < nbits; i++) begin
            out_bit = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            value = {value[30:0], out_bit};
        end
        return value;
    endfunction

    function automatic xlen_t csr_value(input model_t m, input csr_idx_t idx, input logic irq);
        case (idx)
            CSR_MSTATUS: return m.mstatus;
            CSR_MIE:     return m.mie;
            CSR_MTVEC:   return m.mtvec;
            CSR_MEPC:    return m.mepc;
            CSR_MCAUSE:  return m.mcause;
            CSR_MTVAL:   return m.mtval;
            CSR_MIP:     return xlen_t'(irq) << MIE_MEIE_BIT;
            CSR_MHARTID: return xlen_t'(HART_ID);
            default:     return '0;
        endcase
    endfunction

    function automatic model_t ref_cycle(input model_t m, input stim_t s,
                                         output logic ill, output xlen_t rval,
                                         output logic redir, output xlen_t rpc);
        model_t n;
        logic   rd_bad;
        logic   wr_bad;
        logic   irq_on;
        logic   trap;
        xlen_t  cause;
        xlen_t  tval;
        xlen_t  base;
        n = m;
        rd_bad = s.access && (int'(s.ridx[9:8]) > int'(m.mode));
        wr_bad = s.write && ((int'(s.widx[9:8]) > int'(m.mode)) ||
                             (s.widx[11:10] == 2'b11) || (s.widx == CSR_MIP));
        ill = rd_bad || wr_bad;
        rval = (s.access && !ill) ? csr_value(m, s.ridx, s.irq) : '0;

        // interrupt, then illegal or mret from U, then ecall
        irq_on = s.irq && m.mstatus[MSTATUS_MIE_BIT] && m.mie[MIE_MEIE_BIT];
        trap = 1'b1;
        tval = '0;
        cause = '0;
        if (irq_on) begin
            cause = CAUSE_M_EXT_IRQ;
        end else if (s.illegal || (s.mret && m.mode == MODE_U)) begin
            cause = CAUSE_ILLEGAL;
            tval = s.illegal ? s.tval : '0;
        end else if (s.ecall) begin
            cause = (m.mode == MODE_M) ? CAUSE_ECALL_M : CAUSE_ECALL_U;
        end else begin
            trap = 1'b0;
        end

        base = m.mtvec & 32'hFFFF_FFFC;
        redir = trap || s.mret;
        if (trap && irq_on && m.mtvec[0]) begin
            rpc = base + 4 * (cause & 32'h7FFF_FFFF);
        end else if (trap) begin
            rpc = base;
        end else begin
            rpc = m.mepc;
        end

        if (s.write && !wr_bad) begin
            case (s.widx)
                CSR_MSTATUS: begin
                    // MIE and MPIE kept and MPP only U or M
                    n.mstatus = s.wval & 32'h0000_0088;
                    if (s.wval[12:11] == 2'b11) begin
                        n.mstatus[12:11] = 2'b11;
                    end
                end
                CSR_MTVEC:  n.mtvec = s.wval & 32'hFFFF_FFFD;
                CSR_MIE:    n.mie = s.wval & (32'h1 << MIE_MEIE_BIT);
                CSR_MEPC:   n.mepc = s.wval;
                CSR_MCAUSE: n.mcause = s.wval;
                CSR_MTVAL:  n.mtval = s.wval;
                default: ;
            endcase
        end else if (trap) begin
            n.mepc = s.pc;
            n.mcause = cause;
            n.mtval = tval;
            n.mstatus[MSTATUS_MPIE_BIT] = m.mstatus[MSTATUS_MIE_BIT];
            n.mstatus[MSTATUS_MIE_BIT] = 1'b0;
            n.mstatus[MSTATUS_MPP_LSB +: 2] = m.mode;
            n.mode = MODE_M;
        end else if (s.mret) begin
            n.mode = priv_mode_t'(m.mstatus[MSTATUS_MPP_LSB +: 2]);
            n.mstatus[MSTATUS_MIE_BIT] = m.mstatus[MSTATUS_MPIE_BIT];
            n.mstatus[MSTATUS_MPIE_BIT] = 1'b1;
            n.mstatus[MSTATUS_MPP_LSB +: 2] = MODE_U;
        end
        return n;
    endfunction

    task automatic check_val(input string name, input xlen_t exp, input xlen_t got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s expected %h got %h", name, exp, got);
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst) begin
            model = '0;
            model.mode = MODE_M;
            model.mstatus[MSTATUS_MPP_LSB +: 2] = 2'b11;
        end else begin
            model_next = ref_cycle(model, stim, exp_ill, exp_rval, exp_redir, exp_pc);
            check_val("o_mode", xlen_t'(model.mode), xlen_t'(mode));
            check_val("o_csr_illegal", xlen_t'(exp_ill), xlen_t'(csr_illegal));
            if (stim.access) begin
                check_val("o_csr_read_val", exp_rval, csr_read_val);
            end
            check_val("o_redirect", xlen_t'(exp_redir), xlen_t'(redirect));
            if (exp_redir) begin
                check_val("o_redirect_pc", exp_pc, redirect_pc);
            end
            model = model_next;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, run exceeded %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic stim_t quiet();
        stim_t s;
        s = '0;
        s.irq = irq_level;
        return s;
    endfunction

    task automatic drive(input stim_t s);
        @(posedge clk);
        stim <= s;
    endtask

    task automatic idle();
        drive(quiet());
    endtask

    task automatic csr_write(input csr_idx_t idx, input xlen_t val);
        stim_t s;
        s = quiet();
        s.write = 1'b1;
        s.widx = idx;
        s.wval = val;
        drive(s);
    endtask

    task automatic csr_read(input csr_idx_t idx);
        stim_t s;
        s = quiet();
        s.access = 1'b1;
        s.ridx = idx;
        drive(s);
    endtask

    task automatic raise_event(input logic ecall, input logic illegal, input logic mret,
                               input xlen_t pc, input xlen_t tval);
        stim_t s;
        s = quiet();
        s.ecall = ecall;
        s.illegal = illegal;
        s.mret = mret;
        s.pc = pc;
        s.tval = tval;
        drive(s);
    endtask

    initial begin
        csr_idx_t writable [6];
        xlen_t    tvec;
        writable = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL};
        clk = 1'b0;
        rst = 1'b1;
        stim = '0;
        irq_level = 1'b0;
        lfsr_state = 32'd67870;
        errors = 0;
        checks = 0;
        cycles = 0;
        sva_fails = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // random csr writes read back through the legal masks
        foreach (writable[i]) begin
            repeat (2) begin
                csr_write(writable[i], rand_bits(32));
                csr_read(writable[i]);
            end
        end
        csr_read(CSR_MHARTID);
        csr_write(CSR_MIP, rand_bits(32));
        csr_write(CSR_MHARTID, rand_bits(32));
        csr_read(CSR_MIP);
        csr_read(CSR_MHARTID);

        // ecall from M in direct mode
        tvec = rand_bits(32) & 32'hFFFF_FFFC;
        csr_write(CSR_MTVEC, tvec);
        csr_write(CSR_MSTATUS, 32'h0000_1808);
        raise_event(1'b1, 1'b0, 1'b0, rand_bits(32), '0);
        csr_read(CSR_MEPC);
        csr_read(CSR_MCAUSE);
        csr_read(CSR_MTVAL);
        csr_read(CSR_MSTATUS);

        // mret into U, then ecall back to M
        csr_write(CSR_MSTATUS, 32'h0);
        csr_write(CSR_MEPC, rand_bits(32) & 32'hFFFF_FFFC);
        raise_event(1'b0, 1'b0, 1'b1, rand_bits(32), '0);
        csr_read(CSR_MSTATUS);
        raise_event(1'b1, 1'b0, 1'b0, rand_bits(32), '0);
        csr_read(CSR_MSTATUS);
        csr_read(CSR_MCAUSE);

        // illegal instruction, then mret issued from U
        raise_event(1'b0, 1'b1, 1'b0, rand_bits(32), rand_bits(32));
        csr_read(CSR_MCAUSE);
        csr_read(CSR_MTVAL);
        csr_read(CSR_MSTATUS);
        csr_write(CSR_MSTATUS, 32'h0);
        raise_event(1'b0, 1'b0, 1'b1, rand_bits(32), '0);
        raise_event(1'b0, 1'b0, 1'b1, rand_bits(32), rand_bits(32));
        csr_read(CSR_MCAUSE);
        csr_read(CSR_MTVAL);

        // irq held high while enables are applied one at a time
        irq_level = 1'b1;
        csr_write(CSR_MIE, 32'h0);
        csr_write(CSR_MTVEC, tvec | 32'h1);
        csr_write(CSR_MSTATUS, 32'h0000_1808);
        idle();
        csr_write(CSR_MSTATUS, 32'h0000_1800);
        csr_write(CSR_MIE, 32'h0000_0800);
        idle();
        csr_write(CSR_MSTATUS, 32'h0000_1808);
        raise_event(1'b1, 1'b0, 1'b0, rand_bits(32), '0);
        csr_read(CSR_MCAUSE);
        csr_write(CSR_MTVEC, tvec);
        csr_write(CSR_MSTATUS, 32'h0000_1808);
        raise_event(1'b0, 1'b0, 1'b0, rand_bits(32), '0);
        csr_read(CSR_MIP);
        irq_level = 1'b0;
        csr_read(CSR_MCAUSE);
        idle();
        idle();
        @(posedge clk);

        sva_fails = machine_priv_unit_inst.machine_priv_unit_sva_inst.fail_count;
        $display("checks: %0d errors: %0d assertion failures: %0d",
                 checks, errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
priv_pkg.sv
csr_port_if.sv
trap_if.sv
priv_ctrl.sv
trap_ctrl.sv
machine_priv_unit.sv
machine_priv_unit_sva.sv
tb_machine_priv_unit.sv

//--- Bender.yml
package:
  name: machine_priv_unit

sources:
  - priv_pkg.sv
  - csr_port_if.sv
  - trap_if.sv
  - priv_ctrl.sv
  - trap_ctrl.sv
  - machine_priv_unit.sv
  - target: test
    files:
      - machine_priv_unit_sva.sv
      - tb_machine_priv_unit.sv
